// ==== asyncFifoWide.sv ====
// 144 bit dual-clock FIFO built from two 72 bit lanes in lockstep
// wr_rst_q and rd_rst_q arrive already registered in their own clock domain
// dout is valid whenever empty is low, read with rdEn
`timescale 1ns/1ps
`include "fifoWide_consts.svh"

module asyncFifoWide
    import fifoDataPkg::*;
(
    input  logic     wr_clk,
    input  logic     wr_rst_q,
    input  logic     rd_clk,
    input  logic     rd_rst_q,
    input  laneWordU din,
    input  logic     wrEn,
    input  logic     rdEn,
    output laneWordU dout,
    output logic     full,
    output logic     empty
);

    ////////////////////
    // lane wiring
    ////////////////////
    laneWordU                       laneData;    // registered write word
    logic                           laneWrite;
    logic                           laneRead;
    wire  [`NUM_LANES-1:0]          laneAlmostFull;
    wire  [`NUM_LANES-1:0]          laneEmpty;
    wire  [`NUM_LANES-1:0]          laneAlmostEmpty;
    wire  laneSliceT [`NUM_LANES-1:0] laneRdData; // per lane read slices

    fifoWriteStage writeStage (
        .wr_clk         (wr_clk),
        .wr_rst_q       (wr_rst_q),
        .din            (din),
        .wrEn           (wrEn),
        .laneAlmostFull (laneAlmostFull),
        .laneData       (laneData),
        .laneWrite      (laneWrite),
        .full           (full)
    );

    // low slice
    fifoLane lane0 (
        .wr_clk      (wr_clk),
        .wr_rst_q    (wr_rst_q),
        .rd_clk      (rd_clk),
        .rd_rst_q    (rd_rst_q),
        .write       (laneWrite),
        .wrData      (laneData.lanes[0]),
        .read        (laneRead),
        .rdData      (laneRdData[0]),
        .empty       (laneEmpty[0]),
        .almostEmpty (laneAlmostEmpty[0]),
        .almostFull  (laneAlmostFull[0])
    );

    // high slice
    fifoLane lane1 (
        .wr_clk      (wr_clk),
        .wr_rst_q    (wr_rst_q),
        .rd_clk      (rd_clk),
        .rd_rst_q    (rd_rst_q),
        .write       (laneWrite),
        .wrData      (laneData.lanes[1]),
        .read        (laneRead),
        .rdData      (laneRdData[1]),
        .empty       (laneEmpty[1]),
        .almostEmpty (laneAlmostEmpty[1]),
        .almostFull  (laneAlmostFull[1])
    );

    fifoReadFlags readFlags (
        .rd_clk          (rd_clk),
        .rd_rst_q        (rd_rst_q),
        .rdEn            (rdEn),
        .laneEmpty       (laneEmpty),
        .laneAlmostEmpty (laneAlmostEmpty),
        .empty           (empty),
        .laneRead        (laneRead)
    );

    assign dout.lanes = laneRdData;              // rejoin slices, lane 0 low

endmodule

// ==== asyncFifoWide_checker.sv ====
// lane assertions, bound into every fifoLane instance
// wrCount is the write side view, never below the true fill
`timescale 1ns/1ps
`include "fifoWide_consts.svh"

module asyncFifoWide_checker
    import fifoPtrPkg::*;
(
    input logic    wr_clk,
    input logic    wr_rst_q,
    input logic    rd_clk,
    input logic    rd_rst_q,
    input logic    write,
    input logic    read,
    input logic    empty,
    input grayPtrT wrPtrGray,
    input grayPtrT rdPtrGray,
    input ptrT     wrCount
);

    ////////////////////
    // pointer crossing
    ////////////////////
    wrGrayStep: assert property (@(posedge wr_clk) disable iff (wr_rst_q)
        $countones(wrPtrGray ^ $past(wrPtrGray)) <= 1)
        else $error("write gray pointer changed more than one bit");

    rdGrayStep: assert property (@(posedge rd_clk) disable iff (rd_rst_q)
        $countones(rdPtrGray ^ $past(rdPtrGray)) <= 1)
        else $error("read gray pointer changed more than one bit");

    ////////////////////
    // strobes
    ////////////////////
    noWriteWhenFull: assert property (@(posedge wr_clk) disable iff (wr_rst_q)
        write |-> wrCount < ptrT'(`DEPTH))
        else $error("lane written while holding DEPTH entries");

    noReadWhenEmpty: assert property (@(posedge rd_clk) disable iff (rd_rst_q)
        read |-> !empty)
        else $error("lane read while its output register is empty");

endmodule

bind fifoLane asyncFifoWide_checker laneChecker (
    .wr_clk    (wr_clk),
    .wr_rst_q  (wr_rst_q),
    .rd_clk    (rd_clk),
    .rd_rst_q  (rd_rst_q),
    .write     (write),
    .read      (read),
    .empty     (empty),
    .wrPtrGray (wrPtrGray),
    .rdPtrGray (rdPtrGray),
    .wrCount   (wrCount)
);

// ==== fifoDataPkg.sv ====
// data word types of the wide FIFO
// lane 0 always holds the low bits of a word
`include "fifoWide_consts.svh"

package fifoDataPkg;

    ////////////////////
    // lane slice
    ////////////////////
    typedef logic [`LANE_WIDTH-1:0] laneSliceT;  // payload of one lane

    ////////////////////
    // full word
    ////////////////////
    // same 144 bits seen either whole or per lane
    typedef union packed {
        logic [`WORD_WIDTH-1:0]           flat;   // whole word as the user sees it
        laneSliceT [`NUM_LANES-1:0]       lanes;  // lanes[0] = low slice
    } laneWordU;

endpackage

// ==== fifoLane.sv ====
// one 72 bit dual-clock lane, 32 entries, first-word-fall-through output
// pointers cross as gray code through SYNC_STAGES flops, so flags are conservative
// the caller must not write past almostFull plus the write stage depth
`timescale 1ns/1ps
`include "fifoWide_consts.svh"

module fifoLane
    import fifoDataPkg::*;
    import fifoPtrPkg::*;
(
    input  logic      wr_clk,
    input  logic      wr_rst_q,
    input  logic      rd_clk,
    input  logic      rd_rst_q,
    input  logic      write,
    input  laneSliceT wrData,
    input  logic      read,                      // consume the word on rdData
    output laneSliceT rdData,
    output logic      empty,                     // rdData holds no valid word
    output logic      almostEmpty,
    output logic      almostFull
);

    ////////////////////
    // storage
    ////////////////////
    laneSliceT mem [`DEPTH];

    // write domain
    ptrT     wrPtrBin;
    grayPtrT wrPtrGray;
    grayPtrT rdGraySync [`SYNC_STAGES];          // read pointer seen on wr_clk
    ptrT     rdPtrSyncBin;
    ptrT     wrCount;                            // occupancy, write side view

    // read domain
    ptrT     rdPtrBin;
    grayPtrT rdPtrGray;
    grayPtrT wrGraySync [`SYNC_STAGES];          // write pointer seen on rd_clk
    ptrT     wrPtrSyncBin;
    ptrT     memCount;                           // entries still in memory
    ptrT     rdCount;                            // memory plus output register
    logic    memEmpty;
    logic    outValid;
    logic    loadOut;

    ////////////////////
    // write side
    ////////////////////
    always_ff @(posedge wr_clk) begin
        if (write) begin
            mem[wrPtrBin[`DEPTH_LOG2-1:0]] <= wrData;
        end
    end

    always_ff @(posedge wr_clk) begin
        if (wr_rst_q) begin
            wrPtrBin  <= '0;
            wrPtrGray <= '0;
        end else if (write) begin
            wrPtrBin  <= wrPtrBin + 1'b1;
            wrPtrGray <= bin2gray(wrPtrBin + 1'b1); // registered, glitch free crossing
        end
    end

    // read pointer into the write domain
    always_ff @(posedge wr_clk) begin
        if (wr_rst_q) begin
            rdGraySync <= '{default: '0};
        end else begin
            rdGraySync[0] <= rdPtrGray;
            for (int i = 1; i < `SYNC_STAGES; i++) begin
                rdGraySync[i] <= rdGraySync[i-1];
            end
        end
    end

    assign rdPtrSyncBin = gray2bin(rdGraySync[`SYNC_STAGES-1]);
    assign wrCount      = wrPtrBin - rdPtrSyncBin;  // wrap bit keeps this exact mod 64
    // FLAG_OFFSET or fewer free entries
    assign almostFull   = wrCount >= ptrT'(`DEPTH - `FLAG_OFFSET);

    ////////////////////
    // read side
    ////////////////////
    // write pointer into the read domain
    always_ff @(posedge rd_clk) begin
        if (rd_rst_q) begin
            wrGraySync <= '{default: '0};
        end else begin
            wrGraySync[0] <= wrPtrGray;
            for (int i = 1; i < `SYNC_STAGES; i++) begin
                wrGraySync[i] <= wrGraySync[i-1];
            end
        end
    end

    assign wrPtrSyncBin = gray2bin(wrGraySync[`SYNC_STAGES-1]);
    assign memEmpty     = (rdPtrGray == wrGraySync[`SYNC_STAGES-1]);

    // refill when the output register is free or being consumed
    assign loadOut = ~memEmpty & (~outValid | read);

    always_ff @(posedge rd_clk) begin
        if (rd_rst_q) begin
            rdPtrBin  <= '0;
            rdPtrGray <= '0;
            outValid  <= 1'b0;
        end else if (loadOut) begin
            rdPtrBin  <= rdPtrBin + 1'b1;
            rdPtrGray <= bin2gray(rdPtrBin + 1'b1);
            outValid  <= 1'b1;
        end else if (read) begin
            outValid  <= 1'b0;                   // last word gone, nothing behind it
        end
    end

    // fwft data register, head of the memory
    always_ff @(posedge rd_clk) begin
        if (loadOut) begin
            rdData <= mem[rdPtrBin[`DEPTH_LOG2-1:0]];
        end
    end

    ////////////////////
    // read flags
    ////////////////////
    assign empty       = ~outValid;
    assign memCount    = wrPtrSyncBin - rdPtrBin;
    assign rdCount     = memCount + ptrT'(outValid); // count the word on rdData too
    assign almostEmpty = rdCount < ptrT'(`FLAG_OFFSET);

endmodule

// ==== fifoPtrPkg.sv ====
// pointer types for the dual-clock lanes
// pointers carry one wrap bit above the address
`include "fifoWide_consts.svh"

package fifoPtrPkg;

    typedef logic [`DEPTH_LOG2:0] ptrT;       // binary, wrap bit on top
    typedef logic [`DEPTH_LOG2:0] grayPtrT;   // gray coded, same size

    // binary to gray, one bit flips per increment
    function automatic grayPtrT bin2gray(ptrT bin);
        return grayPtrT'(bin ^ (bin >> 1));
    endfunction

    // gray to binary, ripple down from the msb
    function automatic ptrT gray2bin(grayPtrT gray);
        ptrT bin;
        bin[`DEPTH_LOG2] = gray[`DEPTH_LOG2];
        for (int i = `DEPTH_LOG2 - 1; i >= 0; i--) begin
            bin[i] = bin[i+1] ^ gray[i];
        end
        return bin;
    endfunction

endpackage

// ==== fifoReadFlags.sv ====
// read side flag merge for the lockstep lanes, on rd_clk
// empty drops outright only while every lane holds FLAG_OFFSET or more words
// near the bottom it rises for a cycle after each read, covering the lane flag latency
`timescale 1ns/1ps
`include "fifoWide_consts.svh"

module fifoReadFlags (
    input  logic                  rd_clk,
    input  logic                  rd_rst_q,
    input  logic                  rdEn,
    input  logic [`NUM_LANES-1:0] laneEmpty,
    input  logic [`NUM_LANES-1:0] laneAlmostEmpty,
    output logic                  empty,
    output logic                  laneRead      // one strobe for all lanes
);

    logic anyEmpty;
    logic anyAlmostEmpty;

    // one lane behind means the whole word is behind
    assign anyEmpty       = |laneEmpty;
    assign anyAlmostEmpty = |laneAlmostEmpty;

    // common strobe keeps the lane pointers identical
    assign laneRead = rdEn & ~empty;

    ////////////////////
    // throttled empty
    ////////////////////
    always_ff @(posedge rd_clk) begin
        if (rd_rst_q) begin
            empty <= 1'b1;
        end else if (!anyAlmostEmpty) begin
            empty <= 1'b0;                       // plenty stored, back to back reads ok
        end else if (laneRead) begin
            empty <= 1'b1;                       // wait for lane flags to settle
        end else begin
            empty <= anyEmpty;
        end
    end

endmodule

// ==== fifoWide_consts.svh ====
// sizes shared by the wide FIFO and its testbench
// FLAG_OFFSET must stay >= 4 so that the words still in the write stage fit after almost full
`ifndef FIFO_WIDE_CONSTS_SVH
`define FIFO_WIDE_CONSTS_SVH

////////////////////
// word layout
////////////////////
`define LANE_WIDTH   72                          // bits per storage lane
`define NUM_LANES    2                           // lanes written in lockstep
`define WORD_WIDTH   144                         // LANE_WIDTH * NUM_LANES

////////////////////
// lane depth and flags
////////////////////
`define DEPTH_LOG2   5
`define DEPTH        32                          // entries per lane, 2**DEPTH_LOG2

// almost full: FLAG_OFFSET or fewer free entries
// almost empty: fewer than FLAG_OFFSET entries stored, output register included
`define FLAG_OFFSET  6

`define SYNC_STAGES  2                           // flops per gray pointer synchronizer

`endif

// ==== fifoWriteStage.sv ====
// input side of the wide FIFO, all on wr_clk
// a word accepted at an edge reaches the lanes two edges later
// full is the lanes' OR'ed almost full, two cycles late, and is high in reset
`timescale 1ns/1ps
`include "fifoWide_consts.svh"

module fifoWriteStage
    import fifoDataPkg::*;
(
    input  logic                  wr_clk,
    input  logic                  wr_rst_q,
    input  laneWordU              din,
    input  logic                  wrEn,
    input  logic [`NUM_LANES-1:0] laneAlmostFull,
    output laneWordU              laneData,      // second stage, goes to the lanes
    output logic                  laneWrite,     // second stage valid
    output logic                  full
);

    ////////////////////
    // input registers
    ////////////////////
    laneWordU dinQ;                              // first stage payload
    logic     validDinQ;                         // first stage valid
    logic     validMiddle;                       // second stage valid
    logic     middleFull;                        // first delay of almost full

    // payload stages, moving alongside the valid bits
    always_ff @(posedge wr_clk) begin
        dinQ     <= din;
        laneData <= dinQ;
    end

    // valid only for offers taken while full is low
    always_ff @(posedge wr_clk) begin
        if (wr_rst_q) begin
            validDinQ   <= 1'b0;
            validMiddle <= 1'b0;
        end else begin
            validDinQ   <= wrEn & ~full;
            validMiddle <= validDinQ;
        end
    end

    assign laneWrite = validMiddle;              // same strobe for every lane

    ////////////////////
    // delayed full
    ////////////////////
    // any lane almost full stops the whole word
    always_ff @(posedge wr_clk) begin
        if (wr_rst_q) begin
            middleFull <= 1'b1;
            full       <= 1'b1;
        end else begin
            middleFull <= |laneAlmostFull;
            full       <= middleFull;
        end
    end

endmodule

// ==== flist.f ====
+incdir+.
fifoDataPkg.sv
fifoPtrPkg.sv
fifoWriteStage.sv
fifoLane.sv
fifoReadFlags.sv
asyncFifoWide.sv
asyncFifoWide_checker.sv
tb_asyncFifoWide.sv

// ==== tb_asyncFifoWide.sv ====
// directed testbench for the 144 bit dual-clock FIFO
// wr_clk 10 ns, rd_clk 14 ns; outputs are sampled on the falling edge of their clock
// a queue of accepted words is the reference model
`timescale 1ns/1ps
`include "fifoWide_consts.svh"

module tb_asyncFifoWide
    import fifoDataPkg::*;
();

    logic     wr_clk;
    logic     wr_rst_q;
    logic     rd_clk;
    logic     rd_rst_q;
    laneWordU din;
    logic     wrEn;
    logic     rdEn;
    laneWordU dout;
    logic     full;
    logic     empty;

    laneWordU model [$];                         // accepted, not yet read
    int       errorCount;
    int       testCount;
    int       failedTests;
    int       startErrors;

    asyncFifoWide asyncFifoWide_inst (
        .wr_clk   (wr_clk),
        .wr_rst_q (wr_rst_q),
        .rd_clk   (rd_clk),
        .rd_rst_q (rd_rst_q),
        .din      (din),
        .wrEn     (wrEn),
        .rdEn     (rdEn),
        .dout     (dout),
        .full     (full),
        .empty    (empty)
    );

    initial begin
        wr_clk = 1'b0;
        forever #5 wr_clk = ~wr_clk;
    end

    initial begin
        rd_clk = 1'b0;
        forever #7 rd_clk = ~rd_clk;             // unrelated to wr_clk
    end

    ////////////////////
    // helpers
    ////////////////////
    function automatic laneWordU randomWord();
        laneWordU     w;
        logic [159:0] raw;
        raw    = {$urandom, $urandom, $urandom, $urandom, $urandom};
        w.flat = raw[`WORD_WIDTH-1:0];
        return w;
    endfunction

    task automatic checkWord(input string name, input laneWordU got, input laneWordU exp);
        if (got !== exp) begin
            $display("** Error: %s = 0x%h, expected 0x%h", name, got.flat, exp.flat);
            errorCount++;
        end
    endtask

    task automatic checkFlag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("** Error: %s = 0x%h, expected 0x%h", name, got, exp);
            errorCount++;
        end
    endtask

    task automatic reportProblem(input string what);
        $display("Error: %s", what);
        errorCount++;
    endtask

    // offer one word; taken if full is low up to the next edge
    task automatic offerWord(input laneWordU w, output bit taken);
        @(posedge wr_clk);
        #1;
        din  = w;
        wrEn = 1'b1;
        @(negedge wr_clk);
        taken = (full === 1'b0);
        if (taken) begin
            model.push_back(w);
        end
    endtask

    // n new words, each offered again until taken
    task automatic writeWords(input int n);
        bit       taken;
        int       tries;
        laneWordU w;
        for (int i = 0; i < n; i++) begin
            taken = 1'b0;
            tries = 0;
            w     = randomWord();
            while (!taken && tries < 100) begin
                offerWord(w, taken);
                tries++;
            end
            if (!taken) begin
                reportProblem("write not taken, full stayed high");
            end
        end
        @(posedge wr_clk);
        #1;
        wrEn = 1'b0;
    endtask

    task automatic setReadEnable(input logic value);
        @(posedge rd_clk);
        #1;
        rdEn = value;
    endtask

    // read n words with rdEn high, each checked against the model head
    task automatic drainWords(input int n);
        int reads;
        int cycles;
        bit prevRead;
        int prevCount;
        reads    = 0;
        cycles   = 0;
        prevRead = 1'b0;
        while (reads < n && cycles < 400) begin
            @(negedge rd_clk);
            cycles++;
            if (rdEn && empty === 1'b0) begin
                // back to back only with FLAG_OFFSET or more unread words
                if (prevRead && prevCount < `FLAG_OFFSET) begin
                    reportProblem("empty low on two read cycles in a row with few words stored");
                end
                prevRead  = 1'b1;
                prevCount = model.size();
                if (model.size() == 0) begin
                    reportProblem("read accepted with nothing written");
                end else begin
                    checkWord("dout", dout, model.pop_front());
                end
                reads++;
            end else begin
                prevRead = 1'b0;
            end
        end
        if (reads < n) begin
            reportProblem("timeout waiting for read data");
        end
    endtask

    task automatic expectEmpty();
        int cycles;
        cycles = 0;
        while (empty !== 1'b1 && cycles < 10) begin
            @(negedge rd_clk);
            cycles++;
        end
        checkFlag("empty", empty, 1'b1);
        // past the throttle cycle empty follows the lanes
        for (int i = 0; i < 4; i++) begin
            @(negedge rd_clk);
            checkFlag("empty", empty, 1'b1);
        end
        if (model.size() != 0) begin
            reportProblem("words left in the model after the drain");
        end
    endtask

    task automatic reportTest(input string name);
        testCount++;
        if (errorCount == startErrors) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, errorCount - startErrors);
            failedTests++;
        end
        startErrors = errorCount;
    endtask

    ////////////////////
    // directed tests
    ////////////////////
    task automatic resetFlags();
        int cycles;
        repeat (9) @(posedge wr_clk);
        @(negedge wr_clk);
        checkFlag("full", full, 1'b1);           // both flags high in reset
        checkFlag("empty", empty, 1'b1);
        @(posedge wr_clk);                       // tenth edge
        #1;
        wr_rst_q = 1'b0;
        @(posedge rd_clk);
        #1;
        rd_rst_q = 1'b0;
        cycles = 0;
        while (full !== 1'b0 && cycles < 4) begin
            @(negedge wr_clk);
            cycles++;
        end
        checkFlag("full", full, 1'b0);
        for (int i = 0; i < 10; i++) begin
            @(negedge rd_clk);
            checkFlag("empty", empty, 1'b1);     // nothing written yet
        end
    endtask

    task automatic singleWordRoundTrip();
        int cycles;
        writeWords(1);
        cycles = 0;
        while (empty !== 1'b0 && cycles < 50) begin
            @(negedge rd_clk);
            cycles++;
        end
        if (empty !== 1'b0) begin
            reportProblem("timeout waiting for empty to fall");
        end else begin
            checkWord("dout", dout, model[0]); // fwft, visible before the read
        end
        setReadEnable(1'b1);
        drainWords(1);
        setReadEnable(1'b0);
        expectEmpty();
    endtask

    task automatic burstInOrder();
        setReadEnable(1'b1);
        fork
            writeWords(20);
            drainWords(20);
        join
        setReadEnable(1'b0);
        expectEmpty();
    endtask

    task automatic fullBackPressure();
        bit taken;
        int fullRun;
        int cycles;
        int accepted;
        fullRun  = 0;
        cycles   = 0;
        accepted = 0;
        while (fullRun < 8 && cycles < 200) begin
            offerWord(randomWord(), taken);
            accepted += taken;
            fullRun = (full === 1'b1) ? fullRun + 1 : 0;
            cycles++;
        end
        @(posedge wr_clk);
        #1;
        wrEn = 1'b0;
        if (fullRun < 8) begin
            reportProblem("full never stayed high without reads");
        end
        if (accepted > `DEPTH) begin
            reportProblem("more words accepted than a lane can hold");
        end
        setReadEnable(1'b1);
        drainWords(model.size());
        setReadEnable(1'b0);
        expectEmpty();
    endtask

    // starts above FLAG_OFFSET, so the drain crosses into throttled reads
    task automatic throttledDrain();
        writeWords(8);
        setReadEnable(1'b1);
        drainWords(8);
        setReadEnable(1'b0);
        expectEmpty();
    endtask

    ////////////////////
    // main sequence
    ////////////////////
    initial begin
        wr_rst_q    = 1'b1;
        rd_rst_q    = 1'b1;
        din         = '0;
        wrEn        = 1'b0;
        rdEn        = 1'b0;
        errorCount  = 0;
        testCount   = 0;
        failedTests = 0;
        startErrors = 0;
        void'($urandom(32'hefc18a5a));

        resetFlags();
        reportTest("reset");
        singleWordRoundTrip();
        reportTest("single word");
        burstInOrder();
        reportTest("burst order");
        fullBackPressure();
        reportTest("back-pressure");
        throttledDrain();
        reportTest("empty throttle");

        $display("%0d tests, %0d failed, %0d errors", testCount, failedTests, errorCount);
        if (errorCount == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule
